// File: sim.f
alpha_pkg.sv
button_pickoff.sv
readout_sequencer.sv
bias_loader.sv
alpha_control_top.sv
tb_clock.sv
tb_checker.sv
tb_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP ?= tb_top
FILELIST ?= sim.f
PASS_TEXT = All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf obj_dir

// File: tb_top.sv
`timescale 1ns/10ps

module tb_top import alpha_pkg::*; ();

	typedef enum logic [2:0] {
		ACT_IDLE,
		ACT_READOUT,
		ACT_LOAD,
		ACT_BOTH,
		ACT_RESTART // second readout press part-way through
	} action_e;

	typedef struct packed {
		action_e action;
		logic [1:0] switches; // bit 0 trig_mid, bit 1 trig_bot
		int hold_min; // button hold in cycles
		int hold_span; // random extra hold
		int repress_at; // cycles from first press to second
	} row_t;

	localparam int ROW_COUNT = 6;
	localparam int SETTLE_CYCLES = 50; // quiet time checked after each row
	localparam int READOUT_CYCLES = 10 * STEP_CYCLES + ADC_CONVERSION_CYCLES;
	localparam row_t ROWS [ROW_COUNT] = '{
		'{ACT_IDLE, 2'b00, 200, 1, 0},
		'{ACT_READOUT, 2'b01, 20, 40, 0},
		'{ACT_LOAD, 2'b00, 20, 40, 0},
		'{ACT_READOUT, 2'b10, 3000, 1000, 0}, // held into the conversion wait
		'{ACT_RESTART, 2'b11, 20, 40, 650},
		'{ACT_BOTH, 2'b11, 20, 40, 0}
	};

	logic clock;
	logic reset;
	logic [1:0] buttons;
	logic [1:0] switches;
	alpha_pins_t pins;
	int row_index;
	logic busy;
	int error_count;
	int check_count;

	tb_clock clock_gen (.clock(clock), .reset(reset));

	alpha_control_top dut (
		.clock(clock),
		.reset(reset),
		.buttons(buttons),
		.switches(switches),
		.pins(pins)
	);

	tb_checker pin_checker (
		.clock(clock),
		.reset(reset),
		.buttons(buttons),
		.switches(switches),
		.row_index(row_index),
		.pins(pins),
		.busy(busy),
		.error_count(error_count),
		.check_count(check_count)
	);

	// worst case for one row, readout is the longer sequence
	function automatic int run_budget();
		int total;
		total = 20;
		for (int r = 0; r < ROW_COUNT; r++) begin
			total += 2 * (ROWS[r].hold_min + ROWS[r].hold_span) + ROWS[r].repress_at
				+ PICKOFF_DEPTH + 2 + READOUT_CYCLES + SETTLE_CYCLES;
		end
		return total;
	endfunction

	// called on a falling edge, returns on one
	task automatic press(input logic [1:0] mask, input int hold);
		buttons = mask;
		repeat (hold) @(negedge clock);
		buttons = 2'b00;
	endtask

	task automatic run_row(input int r);
		row_t row;
		int hold;
		int errors_before;
		row = ROWS[r];
		hold = row.hold_min + int'($urandom % row.hold_span);
		errors_before = error_count;
		row_index = r;
		switches = row.switches;
		case (row.action)
			ACT_READOUT: press(2'b01, hold);
			ACT_LOAD: press(2'b10, hold);
			ACT_BOTH: press(2'b11, hold);
			ACT_RESTART: begin
				press(2'b01, hold);
				repeat (row.repress_at - hold) @(negedge clock);
				press(2'b01, hold);
			end
			default: repeat (hold) @(negedge clock);
		endcase
		while (busy) @(negedge clock); // sequences finish on their own
		repeat (SETTLE_CYCLES) @(negedge clock);
		$display("row %0d %s switches %b hold %0d: %s, %0d errors", r, row.action.name(),
			row.switches, hold, (error_count == errors_before) ? "ok" : "failed",
			error_count - errors_before);
	endtask

	initial begin
		buttons = 2'b00;
		switches = 2'b00;
		row_index = 0;
		void'($urandom(32'h5d613c3f));
		@(negedge reset);
		repeat (20) @(negedge clock); // pins must stay low with no press
		for (int r = 0; r < ROW_COUNT; r++) begin
			run_row(r);
		end
		$display("%0d rows, %0d checks, %0d errors", ROW_COUNT, check_count, error_count);
		if (error_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		repeat (2 * run_budget()) @(posedge clock);
		$display("timeout: rows still running after %0d clock cycles", 2 * run_budget());
		$display("Some tests failed");
		$finish;
	end

endmodule

// File: tb_checker.sv
`timescale 1ns/10ps

// cycle model of both chip sequences, compared with the pins on every clock
module tb_checker import alpha_pkg::*; (
	input logic clock,
	input logic reset,
	input logic [1:0] buttons,
	input logic [1:0] switches,
	input int row_index,
	input alpha_pins_t pins,
	output logic busy,
	output int error_count,
	output int check_count
);

	localparam int START_DELAY = PICKOFF_DEPTH + 2; // press sample to first visible start cycle
	localparam int READOUT_END = 9 * STEP_CYCLES + ADC_CONVERSION_CYCLES; // counted from dreset
	localparam int BIT_CYCLES = 3 * SERIAL_STEP_CYCLES;
	localparam int WORD_CYCLES = (BIAS_WORD_BITS + 1) * BIT_CYCLES; // bits plus latch
	localparam int LOAD_END = BIAS_WORD_COUNT * WORD_CYCLES;

	logic [1:0] buttons_prev;
	int ro_wait; // samples left until a new readout start shows
	int ld_wait;
	int ro_pos; // 0 is the first dreset cycle
	int ld_pos; // 0 is the first cycle of word 0
	logic ro_active;
	logic ld_active;
	logic [2:0] ld_prev; // model sin/sclk/pclk one cycle back
	logic [BIAS_WORD_BITS-1:0] shift_word;
	int words_seen;

	assign busy = ro_active || ld_active || (ro_wait != 0) || (ld_wait != 0);

	// {dreset, sync, token, trig}
	function automatic logic [3:0] readout_levels(input int p);
		logic [3:0] lv;
		lv[3] = (p >= 0) && (p < STEP_CYCLES);
		lv[2] = (p >= 2 * STEP_CYCLES) && (p < 3 * STEP_CYCLES);
		lv[1] = ((p >= 4 * STEP_CYCLES) && (p < 5 * STEP_CYCLES))
			|| (p >= 8 * STEP_CYCLES + ADC_CONVERSION_CYCLES); // second token
		lv[0] = (p >= 6 * STEP_CYCLES) && (p < 7 * STEP_CYCLES);
		return lv;
	endfunction

	// {sin, sclk, pclk}, msb first then the latch pulse
	function automatic logic [2:0] load_levels(input int p);
		logic [BIAS_WORD_BITS-1:0] word;
		int r;
		int q;
		word = BIAS_TABLE[p / WORD_CYCLES];
		r = p % WORD_CYCLES;
		q = r % BIT_CYCLES; // also the latch offset, bits end on a bit boundary
		if (r < BIAS_WORD_BITS * BIT_CYCLES) begin
			return {word[BIAS_WORD_BITS - 1 - r / BIT_CYCLES],
				(q >= SERIAL_STEP_CYCLES) && (q < 2 * SERIAL_STEP_CYCLES), 1'b0};
		end
		return {word[0], 1'b0, (q >= SERIAL_STEP_CYCLES) && (q < 2 * SERIAL_STEP_CYCLES)};
	endfunction

	task automatic check_bit(input string name, input logic expected, input logic actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("error at %0d ns, row %0d: %s expected %b, actual %b",
				$time, row_index, name, expected, actual);
		end
	endtask

	// pins read here still hold the values from before this edge
	always @(posedge clock) begin : compare
		logic [3:0] ro_exp;
		logic [2:0] ld_exp;
		logic [BIAS_WORD_BITS-1:0] table_word;
		if (reset) begin
			buttons_prev = buttons;
			ro_wait = 0;
			ld_wait = 0;
			ro_active = 1'b0;
			ld_active = 1'b0;
			ld_prev = '0;
			error_count = 0;
			check_count = 0;
		end else begin
			// an old sequence runs on until the new start reaches it
			if (ro_active) begin
				ro_pos++;
			end
			if (ro_wait != 0) begin
				ro_wait--;
				if (ro_wait == 0) begin
					ro_active = 1'b1;
					ro_pos = -STEP_CYCLES; // lead gap
				end
			end
			ro_active = ro_active && (ro_pos < READOUT_END);
			if (ld_active) begin
				ld_pos++;
			end
			if (ld_wait != 0) begin
				ld_wait--;
				if (ld_wait == 0) begin
					ld_active = 1'b1;
					ld_pos = 0;
					words_seen = 0;
				end
			end
			ld_active = ld_active && (ld_pos < LOAD_END);

			ro_exp = ro_active ? readout_levels(ro_pos) : 4'b0000;
			ld_exp = ld_active ? load_levels(ld_pos) : 3'b000;
			check_bit("pins.dreset", ro_exp[3], pins.dreset);
			check_bit("pins.sync", ro_exp[2], pins.sync);
			check_bit("pins.token", ro_exp[1], pins.token);
			check_bit("pins.trig_top", ro_exp[0], pins.trig_top);
			check_bit("pins.trig_mid", ro_exp[0] & switches[0], pins.trig_mid);
			check_bit("pins.trig_bot", ro_exp[0] & switches[1], pins.trig_bot);
			check_bit("pins.sin", ld_exp[2], pins.sin);
			check_bit("pins.sclk", ld_exp[1] | ro_exp[3], pins.sclk); // forced by dreset
			check_bit("pins.pclk", ld_exp[0] | ro_exp[3], pins.pclk);

			// chip takes sin on sclk rise, word closes on pclk rise
			if (ld_exp[1] && !ld_prev[1]) begin
				shift_word = {shift_word[BIAS_WORD_BITS-2:0], pins.sin};
			end
			if (ld_exp[0] && !ld_prev[0]) begin
				table_word = BIAS_TABLE[words_seen];
				check_count++;
				if (shift_word !== table_word) begin
					error_count++;
					$display("error at %0d ns, row %0d: bias word %0d expected %h, actual %h",
						$time, row_index, words_seen, table_word, shift_word);
				end
				words_seen++;
			end
			ld_prev = ld_exp;

			if (buttons[0] && !buttons_prev[0]) begin
				ro_wait = START_DELAY;
			end
			if (buttons[1] && !buttons_prev[1]) begin
				ld_wait = START_DELAY;
			end
			buttons_prev = buttons;
		end
	end

endmodule

// File: tb_clock.sv
`timescale 1ns/10ps

// free-running testbench clock plus the power-on reset
module tb_clock (
	output logic clock,
	output logic reset
);

	localparam int HALF_PERIOD_NS = 50; // 100 ns period
	localparam int RESET_CYCLES = 10;

	initial begin
		clock = 1'b0;
		forever #(HALF_PERIOD_NS) clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		reset = 1'b0; // let go on a falling edge like every other input
	end

endmodule

// File: alpha_control_top.sv
`timescale 1ns/10ps

// control logic for the sampling chip: buttons in, chip pins out
module alpha_control_top import alpha_pkg::*; (
	input logic clock,
	input logic reset,
	input logic [BUTTON_COUNT-1:0] buttons, // bit 0 readout, bit 1 bias load
	input logic [1:0] switches, // trig_mid and trig_bot enables
	output alpha_pins_t pins
);

	logic start_readout;
	logic start_load;
	logic dreset;
	logic sync;
	logic token;
	logic trig;
	logic sin;
	logic sclk;
	logic pclk;

	button_pickoff u_pickoff (
		.clock(clock),
		.reset(reset),
		.buttons(buttons),
		.start_readout(start_readout),
		.start_load(start_load)
	);

	readout_sequencer u_readout (
		.clock(clock),
		.reset(reset),
		.start(start_readout),
		.dreset(dreset),
		.sync(sync),
		.token(token),
		.trig(trig)
	);

	bias_loader u_bias (
		.clock(clock),
		.reset(reset),
		.start(start_load),
		.sin(sin),
		.sclk(sclk),
		.pclk(pclk)
	);

	// chip wants its serial clocks high during dreset
	always_comb begin
		pins.dreset = dreset;
		pins.sync = sync;
		pins.token = token;
		pins.trig_top = trig; // top copy always follows
		pins.trig_mid = trig & switches[0];
		pins.trig_bot = trig & switches[1];
		pins.sin = sin;
		pins.sclk = sclk | dreset;
		pins.pclk = pclk | dreset;
	end

endmodule

// File: bias_loader.sv
`timescale 1ns/10ps

// shifts the four bias words into the chip over sin/sclk and latches each with pclk
module bias_loader import alpha_pkg::*; (
	input logic clock,
	input logic reset,
	input logic start,
	output logic sin,
	output logic sclk,
	output logic pclk
);

	localparam logic [BIT_INDEX_BITS-1:0] TOP_BIT = BIT_INDEX_BITS'(BIAS_WORD_BITS - 1);
	localparam logic [WORD_INDEX_BITS-1:0] LAST_WORD = WORD_INDEX_BITS'(BIAS_WORD_COUNT - 1);
	localparam logic [SERIAL_COUNT_BITS-1:0] STEP_LAST = SERIAL_COUNT_BITS'(SERIAL_STEP_CYCLES - 1);

	load_state_e state;
	logic [SERIAL_COUNT_BITS-1:0] edge_count; // cycles since the last edge
	logic [BIT_INDEX_BITS-1:0] bit_index; // msb first
	logic [WORD_INDEX_BITS-1:0] word_index;
	logic [WORD_INDEX_BITS-1:0] next_word;
	logic [BIAS_WORD_BITS-1:0] word_bits; // current table entry as a plain vector
	logic [BIAS_WORD_BITS-1:0] next_word_bits;
	logic step_done;

	assign step_done = (edge_count == STEP_LAST);
	assign next_word = word_index + 1'b1;
	assign word_bits = BIAS_TABLE[word_index];
	assign next_word_bits = BIAS_TABLE[next_word];

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= LD_IDLE;
			edge_count <= '0;
			bit_index <= TOP_BIT;
			word_index <= '0;
			sin <= 1'b0;
			sclk <= 1'b0;
			pclk <= 1'b0;
		end else if (start) begin
			// back to word 0, first bit goes out now
			state <= LD_SET_DATA;
			edge_count <= '0;
			bit_index <= TOP_BIT;
			word_index <= '0;
			sin <= BIAS_TABLE[0][BIAS_WORD_BITS-1];
			sclk <= 1'b0;
			pclk <= 1'b0;
		end else if (state != LD_IDLE) begin
			if (!step_done) begin
				edge_count <= edge_count + 1'b1;
			end else begin
				edge_count <= '0;
				case (state)
					LD_SET_DATA: begin
						state <= LD_CLOCK_HIGH;
						sclk <= 1'b1; // chip samples sin here
					end
					LD_CLOCK_HIGH: begin
						state <= LD_CLOCK_LOW;
						sclk <= 1'b0;
					end
					LD_CLOCK_LOW: begin
						if (bit_index == '0) begin
							state <= LD_LATCH_GAP; // word fully shifted
						end else begin
							state <= LD_SET_DATA;
							bit_index <= bit_index - 1'b1;
							sin <= word_bits[bit_index - 1'b1]; // next bit down
						end
					end
					LD_LATCH_GAP: begin
						state <= LD_LATCH_HIGH;
						pclk <= 1'b1; // parallel load into the register
					end
					LD_LATCH_HIGH: begin
						state <= LD_LATCH_LOW;
						pclk <= 1'b0;
					end
					LD_LATCH_LOW: begin
						if (word_index == LAST_WORD) begin
							state <= LD_IDLE;
							sin <= 1'b0; // park low when done
						end else begin
							state <= LD_SET_DATA;
							word_index <= next_word;
							bit_index <= TOP_BIT;
							sin <= next_word_bits[BIAS_WORD_BITS-1];
						end
					end
					default: state <= LD_IDLE;
				endcase
			end
		end
	end

	// data must be settled for the whole sclk high time
	assert property (
		@(posedge clock) disable iff (reset)
		sclk |-> $stable(sin)
	);

	// shift and latch never overlap
	assert property (
		@(posedge clock) disable iff (reset)
		!(sclk && pclk)
	);

endmodule

// File: readout_sequencer.sv
`timescale 1ns/10ps

// startup and first readout of the chip: dreset, sync, token, trig, wait, token
module readout_sequencer import alpha_pkg::*; (
	input logic clock,
	input logic reset,
	input logic start,
	output logic dreset,
	output logic sync,
	output logic token,
	output logic trig
);

	readout_state_e state;
	readout_state_e next_state;
	logic [READOUT_COUNT_BITS-1:0] count; // cycles spent in this phase
	logic [READOUT_COUNT_BITS-1:0] phase_last; // last count of this phase
	logic phase_done;

	// conversion phase is the only long one
	always_comb begin
		if (state == RO_CONVERT) begin
			phase_last = READOUT_COUNT_BITS'(STEP_CYCLES + ADC_CONVERSION_CYCLES - 1);
		end else begin
			phase_last = READOUT_COUNT_BITS'(STEP_CYCLES - 1);
		end
	end

	assign phase_done = (count == phase_last);

	// fixed order, no branches
	always_comb begin
		case (state)
			RO_LEAD: next_state = RO_DRESET;
			RO_DRESET: next_state = RO_GAP_DRESET;
			RO_GAP_DRESET: next_state = RO_SYNC;
			RO_SYNC: next_state = RO_GAP_SYNC;
			RO_GAP_SYNC: next_state = RO_TOKEN;
			RO_TOKEN: next_state = RO_GAP_TOKEN;
			RO_GAP_TOKEN: next_state = RO_TRIG;
			RO_TRIG: next_state = RO_CONVERT;
			RO_CONVERT: next_state = RO_TOKEN2;
			default: next_state = RO_IDLE; // token2 and idle both end here
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= RO_IDLE;
			count <= '0;
			dreset <= 1'b0;
			sync <= 1'b0;
			token <= 1'b0;
			trig <= 1'b0;
		end else if (start) begin
			// restart from the lead gap, whatever was going on
			state <= RO_LEAD;
			count <= '0;
			dreset <= 1'b0;
			sync <= 1'b0;
			token <= 1'b0;
			trig <= 1'b0;
		end else if (state != RO_IDLE) begin
			if (phase_done) begin
				state <= next_state;
				count <= '0;
				// levels follow the phase we are entering
				dreset <= (next_state == RO_DRESET);
				sync <= (next_state == RO_SYNC);
				token <= (next_state == RO_TOKEN) || (next_state == RO_TOKEN2);
				trig <= (next_state == RO_TRIG);
			end else begin
				count <= count + 1'b1;
			end
		end
	end

	// the chip lines are strictly one at a time
	assert property (
		@(posedge clock) disable iff (reset)
		$onehot0({dreset, sync, token, trig})
	);

	// trigger only after the first token has had its gap
	assert property (
		@(posedge clock) disable iff (reset)
		$rose(trig) |-> ($past(state) == RO_GAP_TOKEN)
	);

endmodule

// File: button_pickoff.sv
`timescale 1ns/10ps

// synchronizes the push-buttons and turns each press into one start pulse
module button_pickoff import alpha_pkg::*; (
	input logic clock,
	input logic reset,
	input logic [BUTTON_COUNT-1:0] buttons,
	output logic start_readout,
	output logic start_load
);

	// oldest sample sits at the top
	logic [BUTTON_COUNT-1:0][PICKOFF_DEPTH:0] pipeline;
	logic [BUTTON_COUNT-1:0] pulse; // registered single-cycle starts

	always_ff @(posedge clock) begin
		if (reset) begin
			pipeline <= '0;
			pulse <= '0;
		end else begin
			for (int i = 0; i < BUTTON_COUNT; i++) begin
				// 0 then 1 at the two oldest stages marks the rising edge
				pulse[i] <= (pipeline[i][PICKOFF_DEPTH:PICKOFF_DEPTH-1] == 2'b01);
				pipeline[i] <= {pipeline[i][PICKOFF_DEPTH-1:0], buttons[i]}; // shift in
			end
		end
	end

	assign start_readout = pulse[0];
	assign start_load = pulse[1];

endmodule

// File: alpha_pkg.sv
package alpha_pkg;

	// readout pulse widths and gaps, in clock cycles
	localparam int STEP_CYCLES = 100; // 70 and 150 both upset the chip
	localparam int ADC_CONVERSION_CYCLES = 8192; // 2*4096 for the wilkinson ramp
	localparam int READOUT_COUNT_BITS = $clog2(STEP_CYCLES + ADC_CONVERSION_CYCLES);

	// legacy serial bias interface
	localparam int SERIAL_STEP_CYCLES = 5; // cycles between sin/sclk/pclk edges
	localparam int SERIAL_COUNT_BITS = $clog2(SERIAL_STEP_CYCLES);
	localparam int BIAS_WORD_BITS = 16;
	localparam int BIAS_WORD_COUNT = 4;
	localparam int BIT_INDEX_BITS = $clog2(BIAS_WORD_BITS);
	localparam int WORD_INDEX_BITS = $clog2(BIAS_WORD_COUNT);

	// push-button front end
	localparam int BUTTON_COUNT = 2; // bit 0 readout, bit 1 bias load
	localparam int PICKOFF_DEPTH = 6;

	// one serial word as the chip expects it, msb first
	typedef struct packed {
		logic [1:0] pad; // always zero
		logic [1:0] address; // register select
		logic [11:0] data; // bias dac code
	} bias_word_t;

	// CMP bias, ISEL, SB bias, DB bias in load order
	localparam bias_word_t BIAS_TABLE [BIAS_WORD_COUNT] = '{
		'{pad: 2'b00, address: 2'd0, data: 12'h9ff}, // CMP bias
		'{pad: 2'b00, address: 2'd1, data: 12'h9ff}, // ISEL
		'{pad: 2'b00, address: 2'd2, data: 12'h9ff}, // SB bias
		'{pad: 2'b00, address: 2'd3, data: 12'h9ff} // DB bias
	};

	typedef enum logic [3:0] {
		RO_IDLE,
		RO_LEAD, // quiet time before dreset
		RO_DRESET,
		RO_GAP_DRESET,
		RO_SYNC,
		RO_GAP_SYNC,
		RO_TOKEN,
		RO_GAP_TOKEN,
		RO_TRIG,
		RO_CONVERT, // adc conversion wait
		RO_TOKEN2 // token again to start readout
	} readout_state_e;

	typedef enum logic [2:0] {
		LD_IDLE,
		LD_SET_DATA, // sin updated
		LD_CLOCK_HIGH,
		LD_CLOCK_LOW,
		LD_LATCH_GAP,
		LD_LATCH_HIGH,
		LD_LATCH_LOW
	} load_state_e;

	// everything the chip sees from us
	typedef struct packed {
		logic dreset;
		logic sync;
		logic token;
		logic trig_top;
		logic trig_mid;
		logic trig_bot;
		logic sin;
		logic sclk;
		logic pclk;
	} alpha_pins_t;

endpackage
